//--- src.f
+incdir+sim
hw/mcalu_pkg.sv
hw/mcalu_issue_latch.sv
hw/simple_alu.sv
hw/booth_multiplier.sv
hw/mcalu_result_buffer.sv
hw/mcalu_top.sv
sim/mcalu_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mcalu_tb \
  -f src.f -o mcalu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mcalu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sim/mcalu_ref_model.svh
// Reference functions giving the expected result of every opcode
`ifndef MCALU_REF_MODEL_SVH
`define MCALU_REF_MODEL_SVH

// Full 64-bit product with operands widened per the multiply variant
function automatic logic [63:0] full_product(input op_t op, input word_t a, input word_t b);
  logic [63:0] wide_a;
  logic [63:0] wide_b;
  wide_a = {32'b0, a};
  wide_b = {32'b0, b};
  if (op == OP_MULH || op == OP_MULHSU) begin
    wide_a[63:32] = {32{a[31]}};
  end
  if (op == OP_MULH) begin
    wide_b[63:32] = {32{b[31]}};
  end
  return wide_a * wide_b;  // Low 64 bits exact in two's complement
endfunction

function automatic word_t shift_right(input word_t a, input logic [4:0] sh, input logic arith);
  word_t fill;
  fill = (arith && a[31]) ? ~(32'hffff_ffff >> sh) : 32'b0;
  return (a >> sh) | fill;
endfunction

function automatic logic less_than(input word_t a, input word_t b, input logic signed_cmp);
  if (signed_cmp && (a[31] != b[31])) begin
    return a[31];  // Negative one is smaller
  end
  return a < b;
endfunction

function automatic word_t expected_result(input op_t op, input word_t a, input word_t b);
  logic [63:0] prod;
  prod = full_product(op, a, b);
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_SLL:  return a << b[4:0];
    OP_SLT:  return {31'b0, less_than(a, b, 1'b1)};
    OP_SLTU: return {31'b0, less_than(a, b, 1'b0)};
    OP_XOR:  return a ^ b;
    OP_SEQ:  return {31'b0, a == b};
    OP_SRA:  return shift_right(a, b[4:0], 1'b1);
    OP_SRL:  return shift_right(a, b[4:0], 1'b0);
    OP_OR:   return a | b;
    OP_AND:  return a & b;
    OP_MUL:  return prod[31:0];
    default: return prod[63:32];  // MULH, MULHSU, MULHU
  endcase
endfunction

`endif

//--- sim/mcalu_tb.sv
// Testbench for the execution unit with clock, reset, stimulus, scoreboard and assertions
`timescale 1ns/1ps

module mcalu_tb;
  import mcalu_pkg::*;

  `include "mcalu_ref_model.svh"

  localparam int TIMEOUT_CYCLES = 200;
  localparam op_t OP_LIST [15] = '{OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SEQ,
    OP_SRA, OP_SRL, OP_OR, OP_AND, OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  localparam word_t EDGE_VALS [6] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
    32'h0000_001f, 32'h0000_0001};

  logic     clk;
  logic     rst_n;
  logic     flush;
  logic     issue_valid;
  logic     issue_ready;
  op_t      issue_op;
  rob_id_t  issue_rob_id;
  reg_idx_t issue_rd;
  word_t    issue_op1;
  word_t    issue_op2;
  logic     wb_valid;
  logic     wb_ready;
  rob_id_t  wb_rob_id;
  reg_idx_t wb_rd;
  word_t    wb_result;

  logic [44:0] exp_q [$];  // {rob id, rd, result} in issue order
  logic [44:0] held_wb;
  logic        stalled;
  rob_id_t     next_rob;
  int          ready_mode;  // 0 ready, 1 random stalls, 2 held low

  mcalu_top mcalu_top_inst (.*);

  always #4 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  always @(negedge clk) begin
    case (ready_mode)
      0: wb_ready = 1'b1;
      1: wb_ready = ($urandom_range(0, 3) != 0);
      default: wb_ready = 1'b0;
    endcase
  end

  // Scoreboard and handshake rules on pre-edge values
  always @(posedge clk) begin
    logic [44:0] want;
    if (rst_n) begin
      assert (exp_q.size() != 0 || flush || (!wb_valid && issue_ready))
        else report_failure("Unit with nothing in flight is not idle");
      assert (!wb_valid || exp_q.size() != 0)
        else report_failure("wb_valid high with no operation in flight");
      assert (exp_q.size() < 2 || !issue_ready || (wb_valid && wb_ready))
        else report_failure("issue_ready high with two operations in flight");
      if (stalled) begin
        assert (wb_valid) else report_failure("wb_valid dropped while wb_ready was low");
        assert ({wb_rob_id, wb_rd, wb_result} == held_wb) else report_failure($sformatf(
          "Mismatch wb_rob_id/wb_rd/wb_result under stall: expected %h, got %h",
          held_wb, {wb_rob_id, wb_rd, wb_result}));
      end
      if (wb_valid && wb_ready) begin
        want = exp_q.pop_front();
        assert (wb_rob_id == want[44:38]) else report_failure($sformatf(
          "Mismatch wb_rob_id: expected %h, got %h", want[44:38], wb_rob_id));
        assert (wb_rd == want[37:32]) else report_failure($sformatf(
          "Mismatch wb_rd: expected %h, got %h", want[37:32], wb_rd));
        assert (wb_result == want[31:0]) else report_failure($sformatf(
          "Mismatch wb_result: expected %h, got %h", want[31:0], wb_result));
      end
      if (flush) begin
        exp_q.delete();
      end
      if (issue_valid && issue_ready) begin
        exp_q.push_back({issue_rob_id, issue_rd,
                         expected_result(issue_op, issue_op1, issue_op2)});
      end
      stalled = wb_valid && !wb_ready && !flush;
      held_wb = {wb_rob_id, wb_rd, wb_result};
    end
  end

  task automatic send_op(input op_t op, input word_t a, input word_t b);
    int waited;
    waited       = 0;
    issue_op     = op;
    issue_op1    = a;
    issue_op2    = b;
    issue_rob_id = next_rob;
    issue_rd     = reg_idx_t'($urandom);
    issue_valid  = 1'b1;
    next_rob     = next_rob + 7'd1;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        report_failure("Timeout waiting for issue_ready");
      end
    end while (!issue_ready);
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > 4 * TIMEOUT_CYCLES) begin
        report_failure("Timeout waiting for all results to be written back");
      end
    end
  endtask

  task automatic run_random(input int count);
    for (int i = 0; i < count; i++) begin
      send_op(OP_LIST[$urandom_range(0, 14)], $urandom, $urandom);
    end
  endtask

  // ADD parked in the buffer, MULHU mid-run, then one flush cycle
  task automatic flush_in_flight();
    ready_mode = 2;
    send_op(OP_ADD, $urandom, $urandom);
    send_op(OP_MULHU, $urandom, $urandom);
    repeat (4) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush      = 1'b0;
    ready_mode = 0;
    @(posedge clk);
    assert (!wb_valid && issue_ready)
      else report_failure("Flush left a result pending or issue_ready low");
    @(negedge clk);
  endtask

  initial begin
    void'($urandom(90565));
    clk          = 1'b0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    issue_valid  = 1'b0;
    issue_op     = OP_ADD;
    issue_rob_id = '0;
    issue_rd     = '0;
    issue_op1    = '0;
    issue_op2    = '0;
    wb_ready     = 1'b1;
    next_rob     = '0;
    ready_mode   = 0;
    stalled      = 1'b0;
    held_wb      = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    assert (!wb_valid && issue_ready) else report_failure("Unit not idle after reset");
    @(negedge clk);

    // Every opcode on edge operand pairs, then random operands
    for (int i = 0; i < 15; i++) begin
      for (int j = 0; j < 6; j++) begin
        for (int k = 0; k < 6; k++) begin
          send_op(OP_LIST[i], EDGE_VALS[j], EDGE_VALS[k]);
        end
      end
      repeat (20) send_op(OP_LIST[i], $urandom, $urandom);
    end
    wait_drained();

    run_random(300);
    wait_drained();
    ready_mode = 1;  // Random writeback stalls
    run_random(300);
    wait_drained();

    flush_in_flight();
    ready_mode = 1;
    run_random(100);
    wait_drained();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- hw/mcalu_top.sv
// Top of the multi-cycle execution unit with latch, ALU, multiplier and result buffer
`timescale 1ns/1ps

module mcalu_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic                  issue_valid,
  output logic                  issue_ready,
  input  mcalu_pkg::op_t        issue_op,
  input  mcalu_pkg::rob_id_t    issue_rob_id,
  input  mcalu_pkg::reg_idx_t   issue_rd,
  input  mcalu_pkg::word_t      issue_op1,
  input  mcalu_pkg::word_t      issue_op2,
  output logic                  wb_valid,
  input  logic                  wb_ready,
  output mcalu_pkg::rob_id_t    wb_rob_id,
  output mcalu_pkg::reg_idx_t   wb_rd,
  output mcalu_pkg::word_t      wb_result
);
  import mcalu_pkg::*;

  logic     alu_valid;
  logic     mul_valid;
  logic     mul_done;
  logic     retire;
  op_t      exec_op;
  word_t    exec_op1;
  word_t    exec_op2;
  rob_id_t  exec_rob_id;
  reg_idx_t exec_rd;
  word_t    alu_result;
  word_t    mul_result;

  mcalu_issue_latch mcalu_issue_latch_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue_op     (issue_op),
    .issue_rob_id (issue_rob_id),
    .issue_rd     (issue_rd),
    .issue_op1    (issue_op1),
    .issue_op2    (issue_op2),
    .retire       (retire),
    .alu_valid    (alu_valid),
    .mul_valid    (mul_valid),
    .exec_op      (exec_op),
    .exec_op1     (exec_op1),
    .exec_op2     (exec_op2),
    .exec_rob_id  (exec_rob_id),
    .exec_rd      (exec_rd)
  );

  simple_alu simple_alu_inst (
    .exec_op    (exec_op),
    .exec_op1   (exec_op1),
    .exec_op2   (exec_op2),
    .alu_result (alu_result)
  );

  booth_multiplier booth_multiplier_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .mul_valid  (mul_valid),
    .exec_op    (exec_op),
    .exec_op1   (exec_op1),
    .exec_op2   (exec_op2),
    .retire     (retire),
    .mul_done   (mul_done),
    .mul_result (mul_result)
  );

  mcalu_result_buffer mcalu_result_buffer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .alu_valid   (alu_valid),
    .alu_result  (alu_result),
    .mul_done    (mul_done),
    .mul_result  (mul_result),
    .exec_rob_id (exec_rob_id),
    .exec_rd     (exec_rd),
    .wb_ready    (wb_ready),
    .retire      (retire),
    .wb_valid    (wb_valid),
    .wb_rob_id   (wb_rob_id),
    .wb_rd       (wb_rd),
    .wb_result   (wb_result)
  );

endmodule

//--- hw/mcalu_result_buffer.sv
// One-entry result buffer that retires finished operations toward writeback
`timescale 1ns/1ps

module mcalu_result_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic                  alu_valid,
  input  mcalu_pkg::word_t      alu_result,
  input  logic                  mul_done,
  input  mcalu_pkg::word_t      mul_result,
  input  mcalu_pkg::rob_id_t    exec_rob_id,
  input  mcalu_pkg::reg_idx_t   exec_rd,
  input  logic                  wb_ready,
  output logic                  retire,
  output logic                  wb_valid,
  output mcalu_pkg::rob_id_t    wb_rob_id,
  output mcalu_pkg::reg_idx_t   wb_rd,
  output mcalu_pkg::word_t      wb_result
);
  import mcalu_pkg::*;

  logic drain;
  logic finishing;

  assign drain     = wb_valid & wb_ready;
  assign finishing = alu_valid | mul_done;  // Never both

  // Room when empty or leaving this cycle
  assign retire = finishing & (~wb_valid | drain) & ~flush;

  // wb_valid is the full flag itself
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else if (flush) begin
      wb_valid <= 1'b0;
    end else if (retire) begin
      wb_valid <= 1'b1;
    end else if (drain) begin
      wb_valid <= 1'b0;
    end
  end

  // Payload only moves on retire, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (retire) begin
      wb_rob_id <= exec_rob_id;
      wb_rd     <= exec_rd;
      if (mul_done) begin
        wb_result <= mul_result;
      end else begin
        wb_result <= alu_result;
      end
    end
  end

endmodule

//--- hw/booth_multiplier.sv
// Sequential radix-4 Booth multiplier for MUL, MULH, MULHSU and MULHU
`timescale 1ns/1ps

module booth_multiplier (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              mul_valid,
  input  mcalu_pkg::op_t    exec_op,
  input  mcalu_pkg::word_t  exec_op1,
  input  mcalu_pkg::word_t  exec_op2,
  input  logic              retire,
  output logic              mul_done,
  output mcalu_pkg::word_t  mul_result
);
  import mcalu_pkg::*;

  mul_state_t             state;
  logic [MUL_CNT_W-1:0]   step_cnt;

  // Upper 34 bits partial product, lower 32 bits multiplier then product low bits
  logic [65:0] acc;
  logic        x0;   // Bit shifted out by the previous step
  logic        inv;  // Pending +1 of the previous negated partial product

  logic        start;
  logic        stepping;
  logic        op1_signed;
  logic        op2_signed;
  logic [33:0] mcand;
  logic [65:0] step_in;
  logic        x0_in;
  logic        inv_in;
  logic [2:0]  booth_bits;
  logic [33:0] pp_mag;
  logic        pp_neg;
  logic [65:0] step_shr;
  logic [65:0] step_out;
  logic [33:0] corr;
  logic [65:0] final_shr;
  logic [65:0] final_sum;

  assign start    = (state == MUL_IDLE) & mul_valid;
  assign stepping = start | (state == MUL_RUN);
  assign mul_done = (state == MUL_DONE);

  assign op1_signed = exec_op[1] ^ exec_op[0];   // MULH, MULHSU
  assign op2_signed = ~exec_op[1] & exec_op[0];  // MULH only
  assign mcand      = {{2{op1_signed & exec_op1[31]}}, exec_op1};

  // First step runs straight from the operands while idle
  assign step_in = (state == MUL_IDLE) ? {34'b0, exec_op2} : acc;
  assign x0_in   = (state == MUL_IDLE) ? 1'b0 : x0;
  assign inv_in  = (state == MUL_IDLE) ? 1'b0 : inv;

  assign booth_bits = {step_in[1:0], x0_in};

  always_comb begin
    case (booth_bits)
      3'b001, 3'b010, 3'b101, 3'b110: pp_mag = mcand;              // +/-1
      3'b011, 3'b100:                 pp_mag = {mcand[32:0], 1'b0}; // +/-2
      default:                        pp_mag = '0;
    endcase
  end

  assign pp_neg = booth_bits[2] & ~(booth_bits[1] & booth_bits[0]);

  // Shift first, then add at the top; the +1 of the last negation lands at bit 30
  assign step_shr = $signed(step_in) >>> 2;
  assign step_out = step_shr + {pp_mag ^ {34{pp_neg}}, 1'b0, inv_in, 30'b0};

  // Booth treats op2 as signed, so add op1 back when op2 is unsigned with MSB set
  assign corr      = (x0 & ~op2_signed) ? mcand : '0;
  assign final_shr = $signed(acc) >>> 2;
  assign final_sum = final_shr + {corr, 1'b0, inv, 30'b0};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= MUL_IDLE;
      step_cnt <= '0;
    end else if (flush) begin
      state    <= MUL_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        MUL_IDLE: begin
          if (mul_valid) begin
            state    <= MUL_RUN;
            step_cnt <= {{(MUL_CNT_W-1){1'b0}}, 1'b1};  // One step already taken
          end
        end
        MUL_RUN: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == MUL_CNT_W'(MUL_STEPS - 1)) begin
            state <= MUL_FINAL;
          end
        end
        MUL_FINAL: state <= MUL_DONE;
        MUL_DONE: begin
          if (retire) begin
            state <= MUL_IDLE;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (stepping) begin
      acc <= step_out;
      x0  <= step_in[1];
      inv <= pp_neg;
    end
    if (state == MUL_FINAL) begin
      mul_result <= (exec_op[1:0] == 2'b00) ? final_sum[31:0] : final_sum[63:32];
    end
  end

endmodule

//--- hw/simple_alu.sv
// Combinational single-cycle integer operations on the held operands
`timescale 1ns/1ps

module simple_alu (
  input  mcalu_pkg::op_t    exec_op,
  input  mcalu_pkg::word_t  exec_op1,
  input  mcalu_pkg::word_t  exec_op2,
  output mcalu_pkg::word_t  alu_result
);
  import mcalu_pkg::*;

  logic [4:0] shamt;
  logic       alt;
  word_t      sra_res;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt = exec_op2[4:0];  // RV32 shift amount
  assign alt   = exec_op[3];

  // Signed and unsigned views of the operands
  assign sra_res     = $signed(exec_op1) >>> shamt;
  assign lt_signed   = $signed(exec_op1) < $signed(exec_op2);
  assign lt_unsigned = exec_op1 < exec_op2;

  always_comb begin
    case (exec_op[2:0])
      3'b000: begin
        if (alt) begin
          alu_result = exec_op1 - exec_op2;  // SUB
        end else begin
          alu_result = exec_op1 + exec_op2;
        end
      end
      3'b001: alu_result = exec_op1 << shamt;
      3'b010: alu_result = {31'b0, lt_signed};
      3'b011: alu_result = {31'b0, lt_unsigned};
      3'b100: begin
        if (alt) begin
          alu_result = {31'b0, exec_op1 == exec_op2};  // SEQ
        end else begin
          alu_result = exec_op1 ^ exec_op2;
        end
      end
      3'b101: begin
        if (alt) begin
          alu_result = exec_op1 >> shamt;  // SRL
        end else begin
          alu_result = sra_res;
        end
      end
      3'b110: alu_result = exec_op1 | exec_op2;
      default: alu_result = exec_op1 & exec_op2;
    endcase
  end

endmodule

//--- hw/mcalu_issue_latch.sv
// Issue latch holding one operation from the reservation station until it retires
`timescale 1ns/1ps

module mcalu_issue_latch (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic                  issue_valid,
  output logic                  issue_ready,
  input  mcalu_pkg::op_t        issue_op,
  input  mcalu_pkg::rob_id_t    issue_rob_id,
  input  mcalu_pkg::reg_idx_t   issue_rd,
  input  mcalu_pkg::word_t      issue_op1,
  input  mcalu_pkg::word_t      issue_op2,
  input  logic                  retire,
  output logic                  alu_valid,
  output logic                  mul_valid,
  output mcalu_pkg::op_t        exec_op,
  output mcalu_pkg::word_t      exec_op1,
  output mcalu_pkg::word_t      exec_op2,
  output mcalu_pkg::rob_id_t    exec_rob_id,
  output mcalu_pkg::reg_idx_t   exec_rd
);
  import mcalu_pkg::*;

  logic full;
  logic accept;

  // A retiring operation frees the slot on the same edge
  assign issue_ready = (~full | retire) & ~flush;
  assign accept      = issue_valid & issue_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (flush) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (retire) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      exec_op     <= issue_op;
      exec_op1    <= issue_op1;
      exec_op2    <= issue_op2;
      exec_rob_id <= issue_rob_id;
      exec_rd     <= issue_rd;
    end
  end

  // Complex bit routes the held op to one engine
  assign alu_valid = full & ~exec_op[4];
  assign mul_valid = full & exec_op[4];

endmodule

//--- hw/mcalu_pkg.sv
// Operand, tag and opcode types, opcode encodings, multiplier constants and state enum
package mcalu_pkg;

  // Operand and result word
  typedef logic [31:0] word_t;

  // Opcode with bit 4 complex, bit 3 alternate and bits 2:0 function
  typedef logic [4:0] op_t;

  // Reorder-buffer tag
  typedef logic [6:0] rob_id_t;

  // Physical destination register
  typedef logic [5:0] reg_idx_t;

  // Single-cycle operations
  localparam op_t OP_ADD  = 5'b00000;
  localparam op_t OP_SUB  = 5'b01000;  // Alternate of ADD
  localparam op_t OP_SLL  = 5'b00001;
  localparam op_t OP_SLT  = 5'b00010;
  localparam op_t OP_SLTU = 5'b00011;
  localparam op_t OP_XOR  = 5'b00100;
  localparam op_t OP_SEQ  = 5'b01100;  // Alternate of XOR
  localparam op_t OP_SRA  = 5'b00101;
  localparam op_t OP_SRL  = 5'b01101;  // Alternate of SRA
  localparam op_t OP_OR   = 5'b00110;
  localparam op_t OP_AND  = 5'b00111;

  // Multiplies with bits 1:0 picking the variant
  localparam op_t OP_MUL    = 5'b10000;  // Low word
  localparam op_t OP_MULH   = 5'b10001;  // Signed x signed, high word
  localparam op_t OP_MULHSU = 5'b10010;  // Signed x unsigned, high word
  localparam op_t OP_MULHU  = 5'b10011;  // Unsigned x unsigned, high word

  // Radix-4 Booth iterations for 32-bit operands
  localparam int MUL_STEPS = 16;

  // Width of the Booth step counter
  localparam int MUL_CNT_W = $clog2(MUL_STEPS);

  typedef enum logic [1:0] {
    MUL_IDLE,   // Waits and takes the first step on start
    MUL_RUN,    // Remaining Booth steps
    MUL_FINAL,  // Unsigned correction and word select
    MUL_DONE    // Result held until retire
  } mul_state_t;

endpackage
